// ==== cpu_core.f ====
logic/cpu_pkg.sv
logic/alu.sv
logic/regfile.sv
logic/controller.sv
logic/pc.sv
logic/regwalls.sv
logic/forward.sv
logic/cpu_core.sv
sim/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_cpu_core -f cpu_core.f \
	&& ./obj_dir/Vtb_cpu_core > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
	import cpu_pkg::*;

	localparam int N_ENTRIES = 26;
	localparam int RES_BASE  = 100;
	localparam int AUX_BASE  = 200;

	localparam int K_ADD   = 0;
	localparam int K_SUB   = 1;
	localparam int K_AND   = 2;
	localparam int K_OR    = 3;
	localparam int K_XOR   = 4;
	localparam int K_SLT   = 5;
	localparam int K_ADDI  = 6;
	localparam int K_ORI   = 7;
	localparam int K_FWD   = 8;
	localparam int K_LDUSE = 9;
	localparam int K_BEQ_T = 10;
	localparam int K_BEQ_N = 11;
	localparam int K_BNE_T = 12;
	localparam int K_BNE_N = 13;
	localparam int K_JAL   = 14;
	localparam int K_J     = 15;
	localparam int K_OVF   = 16;

	// operands and expected results of the test table are filled in at start
	int kind [N_ENTRIES] = '{K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_ADDI, K_ORI,
		K_FWD, K_LDUSE, K_BEQ_T, K_BEQ_N, K_BNE_T, K_BNE_N, K_JAL, K_J, K_OVF,
		K_ADD, K_SUB, K_SLT, K_SLT, K_ADDI, K_ORI, K_FWD, K_LDUSE, K_XOR};
	word_t op_a [N_ENTRIES];
	word_t op_b [N_ENTRIES];
	word_t expected [N_ENTRIES];
	logic  skipped [N_ENTRIES];
	logic  uses_aux [N_ENTRIES];

	logic     clk;
	logic     rst_n;
	word_t    instruction;
	logic     im_read;
	pc_t      im_address;
	logic     dm_read;
	logic     dm_write;
	dm_addr_t dm_address;
	word_t    dm_in;
	word_t    dm_out;
	logic     alu_overflow;

	word_t imem [1024];
	word_t dmem [4096];
	int    write_cnt [4096];
	int    read_cycle [4096];
	int    fetch_cycle [1024];
	int    cycle;
	int    limit;
	int    errors;
	int    checks;
	int    ovf_count;
	int    ovf_pc;
	int    asm_pc;

	cpu_core #(
		.RESET_PC (pc_t'(0))
	) UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.instruction  (instruction),
		.im_read      (im_read),
		.im_address   (im_address),
		.dm_read      (dm_read),
		.dm_write     (dm_write),
		.dm_address   (dm_address),
		.dm_in        (dm_in),
		.dm_out       (dm_out),
		.alu_overflow (alu_overflow)
	);

	// both memories answer in the same cycle
	assign instruction = imem[im_address];
	assign dm_out      = dmem[dm_address];

	always @(posedge clk) begin
		if (dm_write) begin
			dmem[dm_address] <= dm_in;
		end
	end

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	function automatic word_t alu_word(input reg_addr_t rt, input reg_addr_t ra,
		input reg_addr_t rb, input sub_op_t sub);
		return {1'b0, OP_ALU, rt, ra, rb, 5'b0, sub};
	endfunction

	function automatic word_t imm_word(input opcode_t op, input reg_addr_t rt,
		input reg_addr_t ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic word_t movi_word(input reg_addr_t rt, input word_t value);
		return {1'b0, OP_MOVI, rt, value[19:0]};
	endfunction

	function automatic word_t branch_word(input logic bne, input reg_addr_t rt,
		input reg_addr_t ra, input logic [13:0] off);
		return {1'b0, OP_BR, rt, ra, bne, off};
	endfunction

	function automatic word_t jump_word(input logic link, input logic [23:0] off);
		return {1'b0, OP_J, link, off};
	endfunction

	function automatic sub_op_t alu_sub(input int k);
		case (k)
			K_SUB:   return SUB_SUB;
			K_AND:   return SUB_AND;
			K_OR:    return SUB_OR;
			K_XOR:   return SUB_XOR;
			K_SLT:   return SUB_SLT;
			default: return SUB_ADD;
		endcase
	endfunction

	function automatic word_t random_imm20();
		word_t r;
		r = $urandom;
		return {{12{r[19]}}, r[19:0]};
	endfunction

	function automatic logic is_taken(input int k, input word_t a, input word_t b);
		if (k == K_BEQ_T || k == K_BEQ_N) begin
			return a == b;
		end
		return a != b;
	endfunction

	// value that the program stores for each kind
	function automatic word_t rule_result(input int k, input word_t a, input word_t b,
		input int link_pc);
		case (k)
			K_ADD, K_ADDI: return a + b;
			K_SUB:         return a - b;
			K_AND:         return a & b;
			K_OR, K_ORI:   return a | b;
			K_XOR:         return a ^ b;
			K_SLT:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			K_FWD:         return 4 * a + 3 * b;
			K_LDUSE:       return a + a;
			K_JAL:         return word_t'(link_pc);
			K_J:           return a;
			K_OVF:         return 32'h8000_0000;
			default:       return b;
		endcase
	endfunction

	task automatic emit(input word_t w);
		imem[asm_pc] = w;
		asm_pc++;
	endtask

	task automatic assemble_entry(input int i);
		logic [14:0] res;
		logic [14:0] aux;
		int          link;
		logic        tail_store;
		res         = 15'(RES_BASE + i);
		aux         = 15'(AUX_BASE + i);
		link        = 0;
		tail_store  = 1'b1;
		skipped[i]  = 1'b0;
		uses_aux[i] = 1'b0;
		case (kind[i])
			K_ADDI, K_ORI: begin
				emit(movi_word(5'd1, op_a[i]));
				emit(imm_word((kind[i] == K_ADDI) ? OP_ADDI : OP_ORI, 5'd3, 5'd1, op_b[i][14:0]));
			end
			// sources at execute, memory and write-back distance
			K_FWD: begin
				emit(movi_word(5'd1, op_a[i]));
				emit(movi_word(5'd2, op_b[i]));
				emit(alu_word(5'd4, 5'd1, 5'd2, SUB_ADD));
				emit(alu_word(5'd5, 5'd4, 5'd1, SUB_ADD));
				emit(alu_word(5'd6, 5'd4, 5'd5, SUB_ADD));
				emit(alu_word(5'd3, 5'd4, 5'd6, SUB_ADD));
			end
			K_LDUSE: begin
				emit(movi_word(5'd1, op_a[i]));
				emit(imm_word(OP_SWI, 5'd1, 5'd0, aux));
				emit(imm_word(OP_LWI, 5'd2, 5'd0, aux));
				emit(alu_word(5'd3, 5'd2, 5'd2, SUB_ADD));
				uses_aux[i] = 1'b1;
			end
			K_BEQ_T, K_BEQ_N, K_BNE_T, K_BNE_N: begin
				emit(movi_word(5'd1, op_a[i]));
				emit(movi_word(5'd2, op_b[i]));
				emit(branch_word(kind[i] == K_BNE_T || kind[i] == K_BNE_N, 5'd1, 5'd2, 14'd2));
				emit(imm_word(OP_SWI, 5'd1, 5'd0, aux));
				emit(imm_word(OP_SWI, 5'd2, 5'd0, res));
				skipped[i]  = is_taken(kind[i], op_a[i], op_b[i]);
				uses_aux[i] = 1'b1;
				tail_store  = 1'b0;
			end
			K_JAL, K_J: begin
				emit(movi_word(5'd1, op_a[i]));
				link = asm_pc + 1;
				emit(jump_word(kind[i] == K_JAL, 24'd2));
				emit(imm_word(OP_SWI, 5'd1, 5'd0, aux));
				emit(imm_word(OP_SWI, (kind[i] == K_JAL) ? LINK_REG : 5'd1, 5'd0, res));
				skipped[i]  = 1'b1;
				uses_aux[i] = 1'b1;
				tail_store  = 1'b0;
			end
			// doubling up to 2**30 before one add that overflows
			K_OVF: begin
				emit(movi_word(5'd1, 32'h0004_0000));
				repeat (12) begin
					emit(alu_word(5'd1, 5'd1, 5'd1, SUB_ADD));
				end
				emit(alu_word(5'd4, 5'd1, 5'd1, SUB_AND));
				ovf_pc = asm_pc;
				emit(alu_word(5'd3, 5'd1, 5'd1, SUB_ADD));
			end
			default: begin
				emit(movi_word(5'd1, op_a[i]));
				emit(movi_word(5'd2, op_b[i]));
				emit(alu_word(5'd3, 5'd1, 5'd2, alu_sub(kind[i])));
			end
		endcase
		if (tail_store) begin
			emit(imm_word(OP_SWI, 5'd3, 5'd0, res));
		end
		expected[i] = rule_result(kind[i], op_a[i], op_b[i], link);
	endtask

	task automatic check_store(input int addr, input word_t data);
		int idx;
		if (addr >= RES_BASE && addr < RES_BASE + N_ENTRIES) begin
			idx = addr - RES_BASE;
			checks++;
			if (data !== expected[idx]) begin
				$display("** Error at %0t: dm_in (entry %0d) expected %h, got %h",
					$time, idx, expected[idx], data);
				errors++;
			end
			// the stall delays the store by exactly one cycle
			if (kind[idx] == K_LDUSE) begin
				checks++;
				if (cycle != read_cycle[AUX_BASE + idx] + 3) begin
					$display("** Error at %0t: dm_write cycle (entry %0d) expected %0d, got %0d",
						$time, idx, read_cycle[AUX_BASE + idx] + 3, cycle);
					errors++;
				end
			end
		end else if (addr >= AUX_BASE && addr < AUX_BASE + N_ENTRIES) begin
			idx = addr - AUX_BASE;
			checks++;
			if (skipped[idx]) begin
				$display("entry %0d: the slot after a taken branch or jump stored", idx);
				errors++;
			end else if (data !== op_a[idx]) begin
				$display("** Error at %0t: dm_in (entry %0d, first store) expected %h, got %h",
					$time, idx, op_a[idx], data);
				errors++;
			end
		end
	endtask

	task automatic sample_outputs();
		cycle++;
		checks++;
		if (im_read !== 1'b1) begin
			$display("** Error at %0t: im_read expected 1, got %b", $time, im_read);
			errors++;
		end
		if (fetch_cycle[im_address] < 0) begin
			fetch_cycle[im_address] = cycle;
		end
		if (alu_overflow) begin
			ovf_count++;
			checks++;
			if (cycle != fetch_cycle[ovf_pc] + 2) begin
				$display("** Error at %0t: alu_overflow expected 0, got 1", $time);
				errors++;
			end
		end
		if (dm_read && read_cycle[dm_address] < 0) begin
			read_cycle[dm_address] = cycle;
		end
		if (dm_write) begin
			if (write_cnt[dm_address] == 0) begin
				check_store(int'(dm_address), dm_in);
			end
			write_cnt[dm_address]++;
		end
	endtask

	task automatic final_checks();
		for (int i = 0; i < N_ENTRIES; i++) begin
			checks++;
			if (write_cnt[RES_BASE + i] == 0) begin
				$display("entry %0d never stored its result", i);
				errors++;
			end
			if (uses_aux[i] && !skipped[i] && write_cnt[AUX_BASE + i] == 0) begin
				$display("entry %0d: the store before the result store is missing", i);
				errors++;
			end
		end
		checks++;
		if (ovf_count == 0) begin
			$display("alu_overflow never went high for the overflowing add");
			errors++;
		end
	endtask

	initial begin
		rst_n     = 1'b0;
		cycle     = 0;
		errors    = 0;
		checks    = 0;
		ovf_count = 0;
		ovf_pc    = 0;
		asm_pc    = 0;
		void'($urandom(32'h36e4));
		for (int a = 0; a < 1024; a++) begin
			imem[a]        = '0;
			fetch_cycle[a] = -1;
		end
		for (int a = 0; a < 4096; a++) begin
			dmem[a]       <= {20'hd5a00, 12'(a)};
			write_cnt[a]  = 0;
			read_cycle[a] = -1;
		end
		for (int i = 0; i < N_ENTRIES; i++) begin
			op_a[i] = random_imm20();
			op_b[i] = random_imm20();
			case (kind[i])
				K_ADDI:           op_b[i] = {{17{op_b[i][14]}}, op_b[i][14:0]};
				K_ORI:            op_b[i] = {17'b0, op_b[i][14:0]};
				K_BEQ_T, K_BNE_N: op_b[i] = op_a[i];
				K_BEQ_N, K_BNE_T: begin
					if (op_b[i] == op_a[i]) begin
						op_b[i] = op_a[i] ^ 32'h1;
					end
				end
				default: ;
			endcase
		end
		for (int i = 0; i < N_ENTRIES; i++) begin
			assemble_entry(i);
		end
		// park the core on a jump to itself
		emit(jump_word(1'b0, 24'd0));
		limit = 8 * asm_pc + 50;

		repeat (5) @(negedge clk);
		checks++;
		if (im_read || dm_read || dm_write || alu_overflow || im_address != '0) begin
			$display("outputs are not idle while reset is held");
			errors++;
		end
		rst_n = 1'b1;
		while (write_cnt[RES_BASE + N_ENTRIES - 1] == 0 && cycle < limit) begin
			@(negedge clk);
			sample_outputs();
		end
		if (write_cnt[RES_BASE + N_ENTRIES - 1] == 0) begin
			$display("timeout after %0d cycles, the last result store never happened", cycle);
			errors++;
		end
		final_checks();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
	parameter cpu_pkg::pc_t RESET_PC = '0
) (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::word_t     instruction,
	output logic               im_read,
	output cpu_pkg::pc_t       im_address,
	output logic               dm_read,
	output logic               dm_write,
	output cpu_pkg::dm_addr_t  dm_address,
	output cpu_pkg::word_t     dm_in,
	input  cpu_pkg::word_t     dm_out,
	output logic               alu_overflow
);
	import cpu_pkg::*;

	// pipeline registers
	if_id_t  if_id;
	id_ex_t  id_ex;
	id_ex_t  id_ex_next;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	// decode operands
	word_t ra_data;
	word_t rb_data;
	word_t rt_data;
	word_t ra_fwd;
	word_t rb_fwd;
	word_t rt_fwd;

	word_t alu_result;
	word_t mem_result;

	logic stall;
	logic flush;
	logic branch_taken;
	logic jump;
	pc_t  branch_offset;

	alu u_alu (
		.alu_op   (id_ex.ctrl.alu_op),
		.src_a    (id_ex.op_a),
		.src_b    (id_ex.op_b),
		.result   (alu_result),
		.overflow (alu_overflow)
	);

	regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (if_id.instr[19:15]),
		.rb_addr (if_id.instr[14:10]),
		.rt_addr (if_id.instr[24:20]),
		.wr_en   (mem_wb.reg_write),
		.wr_addr (mem_wb.dest),
		.wr_data (mem_wb.result),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rt_data (rt_data)
	);

	controller u_controller (
		.if_id         (if_id),
		.ra_fwd        (ra_fwd),
		.rb_fwd        (rb_fwd),
		.rt_fwd        (rt_fwd),
		.id_ex_next    (id_ex_next),
		.branch_taken  (branch_taken),
		.jump          (jump),
		.branch_offset (branch_offset)
	);

	pc #(
		.RESET_PC (RESET_PC)
	) u_pc (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.branch_taken  (branch_taken),
		.jump          (jump),
		.id_pc         (if_id.pc),
		.branch_offset (branch_offset),
		.im_address    (im_address),
		.im_read       (im_read),
		.flush         (flush)
	);

	regwalls u_regwalls (
		.clk         (clk),
		.rst_n       (rst_n),
		.instruction (instruction),
		.fetch_pc    (im_address),
		.stall       (stall),
		.flush       (flush),
		.id_ex_next  (id_ex_next),
		.alu_result  (alu_result),
		.dm_out      (dm_out),
		.if_id       (if_id),
		.id_ex       (id_ex),
		.ex_mem      (ex_mem),
		.mem_wb      (mem_wb),
		.mem_result  (mem_result),
		.dm_read     (dm_read),
		.dm_write    (dm_write),
		.dm_address  (dm_address),
		.dm_in       (dm_in)
	);

	forward u_forward (
		.if_id      (if_id),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.rt_data    (rt_data),
		.id_ex      (id_ex),
		.alu_result (alu_result),
		.ex_mem     (ex_mem),
		.mem_result (mem_result),
		.mem_wb     (mem_wb),
		.ra_fwd     (ra_fwd),
		.rb_fwd     (rb_fwd),
		.rt_fwd     (rt_fwd),
		.stall      (stall)
	);

endmodule

`default_nettype wire

// ==== logic/forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module forward (
	input  cpu_pkg::if_id_t  if_id,
	input  cpu_pkg::word_t   ra_data,
	input  cpu_pkg::word_t   rb_data,
	input  cpu_pkg::word_t   rt_data,
	input  cpu_pkg::id_ex_t  id_ex,
	input  cpu_pkg::word_t   alu_result,
	input  cpu_pkg::ex_mem_t ex_mem,
	input  cpu_pkg::word_t   mem_result,
	input  cpu_pkg::mem_wb_t mem_wb,
	output cpu_pkg::word_t   ra_fwd,
	output cpu_pkg::word_t   rb_fwd,
	output cpu_pkg::word_t   rt_fwd,
	output logic             stall
);
	import cpu_pkg::*;

	opcode_t   opcode;
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	reg_addr_t rt_addr;
	logic      ex_load;

	assign opcode  = if_id.instr[30:25];
	assign ra_addr = if_id.instr[19:15];
	assign rb_addr = if_id.instr[14:10];
	assign rt_addr = if_id.instr[24:20];

	// youngest writer wins
	function automatic word_t pick(input reg_addr_t addr, input word_t rf);
		if (addr == '0) return rf;
		if (id_ex.ctrl.reg_write && !id_ex.ctrl.dm_read && id_ex.dest == addr) return alu_result;
		if (ex_mem.ctrl.reg_write && ex_mem.dest == addr) return mem_result;
		if (mem_wb.reg_write && mem_wb.dest == addr) return mem_wb.result;
		return rf;
	endfunction

	always_comb begin
		ra_fwd = pick(ra_addr, ra_data);
		rb_fwd = pick(rb_addr, rb_data);
		rt_fwd = pick(rt_addr, rt_data);
	end

	// only fields the decoded instruction really reads
	assign ex_load = id_ex.ctrl.dm_read && id_ex.ctrl.reg_write && (id_ex.dest != '0);
	assign stall = ex_load && (
		((opcode inside {OP_ALU, OP_ADDI, OP_ORI, OP_LWI, OP_SWI, OP_BR}) && id_ex.dest == ra_addr)
		|| ((opcode == OP_ALU) && id_ex.dest == rb_addr)
		|| ((opcode inside {OP_SWI, OP_BR}) && id_ex.dest == rt_addr));

endmodule

`default_nettype wire

// ==== logic/regwalls.sv ====
`timescale 1ns/1ps
`default_nettype none

module regwalls (
	input  logic                clk,
	input  logic                rst_n,
	input  cpu_pkg::word_t      instruction,
	input  cpu_pkg::pc_t        fetch_pc,
	input  logic                stall,
	input  logic                flush,
	input  cpu_pkg::id_ex_t     id_ex_next,
	input  cpu_pkg::word_t      alu_result,
	input  cpu_pkg::word_t      dm_out,
	output cpu_pkg::if_id_t     if_id,
	output cpu_pkg::id_ex_t     id_ex,
	output cpu_pkg::ex_mem_t    ex_mem,
	output cpu_pkg::mem_wb_t    mem_wb,
	output cpu_pkg::word_t      mem_result,
	output logic                dm_read,
	output logic                dm_write,
	output cpu_pkg::dm_addr_t   dm_address,
	output cpu_pkg::word_t      dm_in
);
	import cpu_pkg::*;

	// fetch to decode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id <= '0;
		end else if (flush) begin
			if_id <= '0;
		end else if (!stall) begin
			if_id <= '{instr: instruction, pc: fetch_pc};
		end
	end

	// bubble while decode is held
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (stall) begin
			id_ex <= '0;
		end else begin
			id_ex <= id_ex_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			ex_mem.ctrl       <= id_ex.ctrl;
			ex_mem.result     <= alu_result;
			ex_mem.store_data <= id_ex.store_data;
			ex_mem.dest       <= id_ex.dest;
			mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
			mem_wb.dest       <= ex_mem.dest;
			mem_wb.result     <= mem_result;
		end
	end

	// memory stage
	assign dm_read    = ex_mem.ctrl.dm_read;
	assign dm_write   = ex_mem.ctrl.dm_write;
	assign dm_address = dm_addr_t'(ex_mem.result);
	assign dm_in      = ex_mem.store_data;
	assign mem_result = ex_mem.ctrl.dm_read ? dm_out : ex_mem.result;

endmodule

`default_nettype wire

// ==== logic/pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc #(
	parameter cpu_pkg::pc_t RESET_PC = '0
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         stall,
	input  logic         branch_taken,
	input  logic         jump,
	input  cpu_pkg::pc_t id_pc,
	input  cpu_pkg::pc_t branch_offset,
	output cpu_pkg::pc_t im_address,
	output logic         im_read,
	output logic         flush
);
	import cpu_pkg::*;

	logic redirect;
	pc_t  next_pc;

	// a stalled branch may still see stale operands
	assign redirect = (branch_taken || jump) && !stall;
	assign flush    = redirect;

	always_comb begin
		if (stall) begin
			next_pc = im_address;
		end else if (redirect) begin
			next_pc = id_pc + branch_offset;
		end else begin
			next_pc = im_address + pc_t'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			im_address <= RESET_PC;
			im_read    <= 1'b0;
		end else begin
			im_address <= next_pc;
			im_read    <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller (
	input  cpu_pkg::if_id_t if_id,
	input  cpu_pkg::word_t  ra_fwd,
	input  cpu_pkg::word_t  rb_fwd,
	input  cpu_pkg::word_t  rt_fwd,
	output cpu_pkg::id_ex_t id_ex_next,
	output logic            branch_taken,
	output logic            jump,
	output cpu_pkg::pc_t    branch_offset
);
	import cpu_pkg::*;

	opcode_t   opcode;
	sub_op_t   sub_op;
	reg_addr_t rt_addr;
	word_t     imm15_s;
	word_t     imm15_z;
	word_t     imm20_s;
	word_t     offset;
	pc_t       link_pc;

	assign opcode  = if_id.instr[30:25];
	assign sub_op  = if_id.instr[4:0];
	assign rt_addr = if_id.instr[24:20];

	assign imm15_s = {{17{if_id.instr[14]}}, if_id.instr[14:0]};
	assign imm15_z = {17'b0, if_id.instr[14:0]};
	assign imm20_s = {{12{if_id.instr[19]}}, if_id.instr[19:0]};
	assign link_pc = if_id.pc + pc_t'(1);

	// word offsets, wrapped into the pc range
	assign offset = (opcode == OP_J) ? {{8{if_id.instr[23]}}, if_id.instr[23:0]}
		: {{18{if_id.instr[13]}}, if_id.instr[13:0]};
	assign branch_offset = pc_t'(offset);

	always_comb begin
		id_ex_next   = '0;
		branch_taken = 1'b0;
		jump         = 1'b0;
		case (opcode)
			OP_ALU: begin
				if (sub_op inside {SUB_ADD, SUB_SUB, SUB_AND, SUB_OR, SUB_XOR, SUB_SLT}) begin
					id_ex_next.ctrl.alu_op    = sub_op;
					id_ex_next.ctrl.reg_write = 1'b1;
					id_ex_next.op_a           = ra_fwd;
					id_ex_next.op_b           = rb_fwd;
					id_ex_next.dest           = rt_addr;
				end
			end
			OP_ADDI, OP_ORI, OP_LWI: begin
				id_ex_next.ctrl.alu_op    = (opcode == OP_ORI) ? SUB_OR : SUB_ADD;
				id_ex_next.ctrl.dm_read   = (opcode == OP_LWI);
				id_ex_next.ctrl.reg_write = 1'b1;
				id_ex_next.op_a           = ra_fwd;
				id_ex_next.op_b           = (opcode == OP_ORI) ? imm15_z : imm15_s;
				id_ex_next.dest           = rt_addr;
			end
			OP_MOVI: begin
				id_ex_next.ctrl.alu_op    = SUB_PASSB;
				id_ex_next.ctrl.reg_write = 1'b1;
				id_ex_next.op_b           = imm20_s;
				id_ex_next.dest           = rt_addr;
			end
			OP_SWI: begin
				id_ex_next.ctrl.alu_op   = SUB_ADD;
				id_ex_next.ctrl.dm_write = 1'b1;
				id_ex_next.op_a          = ra_fwd;
				id_ex_next.op_b          = imm15_s;
				id_ex_next.store_data    = rt_fwd;
			end
			OP_BR: begin
				// bit 14 selects bne
				branch_taken = if_id.instr[14] ? (rt_fwd != ra_fwd) : (rt_fwd == ra_fwd);
			end
			OP_J: begin
				jump = 1'b1;
				if (if_id.instr[24]) begin
					id_ex_next.ctrl.alu_op    = SUB_PASSB;
					id_ex_next.ctrl.reg_write = 1'b1;
					id_ex_next.op_b           = word_t'(link_pc);
					id_ex_next.dest           = LINK_REG;
				end
			end
			default: id_ex_next = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_pkg::reg_addr_t   ra_addr,
	input  cpu_pkg::reg_addr_t   rb_addr,
	input  cpu_pkg::reg_addr_t   rt_addr,
	input  logic                 wr_en,
	input  cpu_pkg::reg_addr_t   wr_addr,
	input  cpu_pkg::word_t       wr_data,
	output cpu_pkg::word_t       ra_data,
	output cpu_pkg::word_t       rb_data,
	output cpu_pkg::word_t       rt_data
);
	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// r0 is hardwired
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu_pkg::sub_op_t alu_op,
	input  cpu_pkg::word_t   src_a,
	input  cpu_pkg::word_t   src_b,
	output cpu_pkg::word_t   result,
	output logic             overflow
);
	import cpu_pkg::*;

	word_t sum;
	word_t diff;

	assign sum  = src_a + src_b;
	assign diff = src_a - src_b;

	always_comb begin
		result   = '0;
		overflow = 1'b0;
		case (alu_op)
			SUB_ADD: begin
				result   = sum;
				overflow = (src_a[31] == src_b[31]) && (sum[31] != src_a[31]);
			end
			SUB_SUB: begin
				result   = diff;
				overflow = (src_a[31] != src_b[31]) && (diff[31] != src_a[31]);
			end
			SUB_AND:   result = src_a & src_b;
			SUB_OR:    result = src_a | src_b;
			SUB_XOR:   result = src_a ^ src_b;
			SUB_SLT:   result = {31'b0, $signed(src_a) < $signed(src_b)};
			// movi and jal carry their value in operand b
			SUB_PASSB: result = src_b;
			default:   result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [9:0]  pc_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [11:0] dm_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [4:0]  sub_op_t;

	// major opcodes, instruction bits 30:25
	localparam opcode_t OP_ALU  = 6'b100000;
	localparam opcode_t OP_MOVI = 6'b100010;
	localparam opcode_t OP_J    = 6'b100100;
	localparam opcode_t OP_BR   = 6'b100110;
	localparam opcode_t OP_ADDI = 6'b101000;
	localparam opcode_t OP_ORI  = 6'b101100;
	localparam opcode_t OP_LWI  = 6'b000010;
	localparam opcode_t OP_SWI  = 6'b001010;

	// alu sub-ops, bits 4:0 of an OP_ALU word
	localparam sub_op_t SUB_ADD   = 5'b00000;
	localparam sub_op_t SUB_SUB   = 5'b00001;
	localparam sub_op_t SUB_AND   = 5'b00010;
	localparam sub_op_t SUB_XOR   = 5'b00011;
	localparam sub_op_t SUB_OR    = 5'b00100;
	// signed compare
	localparam sub_op_t SUB_SLT   = 5'b00110;
	// internal only, never taken from an instruction
	localparam sub_op_t SUB_PASSB = 5'b11111;

	localparam reg_addr_t LINK_REG = 5'd30;

	typedef struct packed {
		sub_op_t alu_op;
		logic    dm_read;
		logic    dm_write;
		logic    reg_write;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		pc_t   pc;
	} if_id_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     op_a;
		word_t     op_b;
		word_t     store_data;
		reg_addr_t dest;
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     result;
		word_t     store_data;
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest;
		word_t     result;
	} mem_wb_t;

endpackage

`default_nettype wire
